// File: flist.f
rtl/huff_pkg.sv
rtl/huff_ctrl.sv
rtl/huff_hist.sv
rtl/huff_least.sv
rtl/huff_sram_port.sv
rtl/huff_scratch_ram.sv
rtl/huff_front_top.sv
verif/huff_properties.sv
verif/huff_tb.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module huff_tb \
    -f flist.f -o huff_sim

./obj_dir/huff_sim 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"

// File: verif/huff_tb.sv
`timescale 1ns/1ns

module huff_tb import huff_pkg::*; ();

    localparam int BYTE_TIMEOUT = 5000;   // first byte waits out the clear phase
    localparam int DONE_TIMEOUT = 20000;

    logic   clk;
    logic   rst;
    logic   start;
    logic   sym_valid;
    sym_t   sym;
    logic   sym_last;
    logic   sym_ready;
    logic   done;
    least_t result;

    integer seed;
    int     model_cnt [NUM_SYMS];
    sym_t   frame_q [$];
    int     done_count;
    int     frames_run;

    huff_front_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start),
        .sym_valid_i (sym_valid),
        .sym_i       (sym),
        .sym_last_i  (sym_last),
        .sym_ready_o (sym_ready),
        .done_o      (done),
        .result_o    (result)
    );

    bind huff_sram_port huff_properties i_props (
        .clk          (clk),
        .rst          (rst),
        .axil_req_i   (axil_o),
        .axil_rsp_i   (axil_i),
        .hist_done_i  (hist_rsp_o.done),
        .least_done_i (least_rsp_o.done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial done_count = 0;

    always @(negedge clk) begin
        if (done) done_count <= done_count + 1;
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                     $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Errors found");
        $fatal(1, "wait timed out");
    endtask

    // picks the two smallest nonzero counts with ties to the lowest symbol
    function automatic least_t expected_least();
        least_t r;
        int     first;
        int     second;
        first  = -1;
        second = -1;
        for (int s = 0; s < NUM_SYMS; s++) begin
            if (model_cnt[s] != 0 && (first < 0 || model_cnt[s] < model_cnt[first])) first = s;
        end
        for (int s = 0; s < NUM_SYMS; s++) begin
            if (s != first && model_cnt[s] != 0 &&
                (second < 0 || model_cnt[s] < model_cnt[second])) begin
                second = s;
            end
        end
        r = '0;
        if (first >= 0) begin
            r.first_sym = sym_t'(first);
            r.first_cnt = cnt_t'(model_cnt[first]);
        end
        if (second >= 0) begin
            r.second_sym = sym_t'(second);
            r.second_cnt = cnt_t'(model_cnt[second]);
        end
        return r;
    endfunction

    task automatic send_byte(input sym_t s, input logic last);
        logic [31:0] r;
        int          gap;
        int          waited;
        r   = $random(seed);
        gap = (r[3:0] > 4'd11) ? int'(r[5:4]) + 1 : 0;  // source idles now and then
        repeat (gap) begin
            @(posedge clk);
            sym_valid <= 1'b0;
        end
        @(posedge clk);
        sym_valid <= 1'b1;
        sym       <= s;
        sym_last  <= last;
        waited = 0;
        @(negedge clk);
        while (sym_ready !== 1'b1) begin
            if (waited == BYTE_TIMEOUT) report_timeout("sym_ready_o never rose for a byte");
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic build_random_frame();
        logic [31:0] r;
        int          len;
        sym_t        mask;
        r    = $random(seed);
        len  = 1 + (int'(r[15:0]) % 300);
        case (r[17:16])
            2'd1:    mask = 8'h0f;
            2'd2:    mask = 8'h03;  // few symbols with larger counts
            default: mask = 8'hff;
        endcase
        frame_q.delete();
        repeat (len) begin
            r = $random(seed);
            frame_q.push_back(r[7:0] & mask);
        end
    endtask

    task automatic run_frame();
        least_t exp;
        int     waited;
        foreach (model_cnt[s]) model_cnt[s] = 0;
        foreach (frame_q[i]) model_cnt[frame_q[i]]++;
        exp = expected_least();

        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        foreach (frame_q[i]) send_byte(frame_q[i], i == frame_q.size() - 1);
        @(posedge clk);  // last byte transfers here
        sym_valid <= 1'b0;
        sym_last  <= 1'b0;

        waited = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (waited == DONE_TIMEOUT) report_timeout("done_o never pulsed after a frame");
            waited++;
            @(negedge clk);
        end
        check_equal(32'(result.first_sym), 32'(exp.first_sym), "first_sym");
        check_equal(result.first_cnt, exp.first_cnt, "first_cnt");
        check_equal(result.second_cnt, exp.second_cnt, "second_cnt");
        check_equal(32'(result.second_sym), 32'(exp.second_sym), "second_sym");
        @(negedge clk);
        check_equal(32'(done), 32'd0, "done_o one cycle wide");
        check_equal(32'(done_count), 32'(frames_run + 1), "done_o pulses per frame");
        frames_run++;
    endtask

    initial begin
        seed       = 34;
        frames_run = 0;
        rst        = 1'b1;
        start      = 1'b0;
        sym_valid  = 1'b0;
        sym        = '0;
        sym_last   = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal(32'(done), 32'd0, "done_o after reset");
        check_equal(32'(sym_ready), 32'd0, "sym_ready_o after reset");

        // back to back random frames
        repeat (5) begin
            build_random_frame();
            run_frame();
        end

        // one distinct symbol
        frame_q.delete();
        repeat (7) frame_q.push_back(8'ha5);
        run_frame();
        check_equal(32'(result.first_sym), 32'h0000_00a5, "single symbol first_sym");
        check_equal(result.second_cnt, 32'd0, "single symbol second_cnt");

        // equal minimum counts for 0x20 and 0x40
        frame_q = '{8'h40, 8'h90, 8'h20, 8'h40, 8'h90, 8'h20,
                    8'h90, 8'h40, 8'h20, 8'h90, 8'h90};
        run_frame();
        check_equal(32'(result.first_sym), 32'h0000_0020, "tie first_sym");
        check_equal(32'(result.second_sym), 32'h0000_0040, "tie second_sym");

        build_random_frame();
        run_frame();

        $display("No errors");
        $finish;
    end

endmodule

// File: verif/huff_properties.sv
`timescale 1ns/1ns

module huff_properties import huff_pkg::*; (
    input logic      clk,
    input logic      rst,
    input axil_req_t axil_req_i,
    input axil_rsp_t axil_rsp_i,
    input logic      hist_done_i,
    input logic      least_done_i
);

    // valid held with stable payload until ready
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        axil_req_i.awvalid && !axil_rsp_i.awready |=>
            axil_req_i.awvalid && $stable(axil_req_i.awaddr))
        else $error("awvalid dropped or awaddr changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        axil_req_i.wvalid && !axil_rsp_i.wready |=>
            axil_req_i.wvalid && $stable(axil_req_i.wdata) && $stable(axil_req_i.wstrb))
        else $error("wvalid dropped or write data changed before wready");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        axil_req_i.arvalid && !axil_rsp_i.arready |=>
            axil_req_i.arvalid && $stable(axil_req_i.araddr))
        else $error("arvalid dropped or araddr changed before arready");

    bready_ok: assert property (@(posedge clk) disable iff (rst)
        axil_req_i.bready |-> axil_rsp_i.bvalid)
        else $error("bready without bvalid");

    rready_ok: assert property (@(posedge clk) disable iff (rst)
        axil_req_i.rready |-> axil_rsp_i.rvalid)
        else $error("rready without rvalid");

    hist_pulse: assert property (@(posedge clk) disable iff (rst)
        hist_done_i |=> !hist_done_i)
        else $error("hist response done longer than one cycle");

    least_pulse: assert property (@(posedge clk) disable iff (rst)
        least_done_i |=> !least_done_i)
        else $error("least response done longer than one cycle");

endmodule

// File: rtl/huff_front_top.sv
`timescale 1ns/1ns

module huff_front_top import huff_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start_i,
    input  logic   sym_valid_i,
    input  sym_t   sym_i,
    input  logic   sym_last_i,
    output logic   sym_ready_o,
    output logic   done_o,
    output least_t result_o
);

    phase_t    phase;
    logic      hist_done;
    logic      least_done;
    mem_req_t  hist_req;
    mem_req_t  least_req;
    mem_rsp_t  hist_rsp;
    mem_rsp_t  least_rsp;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;

    huff_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .hist_done_i  (hist_done),
        .least_done_i (least_done),
        .phase_o      (phase),
        .done_o       (done_o)
    );

    huff_hist i_hist (
        .clk         (clk),
        .rst         (rst),
        .phase_i     (phase),
        .sym_valid_i (sym_valid_i),
        .sym_i       (sym_i),
        .sym_last_i  (sym_last_i),
        .sym_ready_o (sym_ready_o),
        .req_o       (hist_req),
        .rsp_i       (hist_rsp),
        .done_o      (hist_done)
    );

    huff_least i_least (
        .clk      (clk),
        .rst      (rst),
        .phase_i  (phase),
        .req_o    (least_req),
        .rsp_i    (least_rsp),
        .done_o   (least_done),
        .result_o (result_o)
    );

    huff_sram_port i_port (
        .clk         (clk),
        .rst         (rst),
        .phase_i     (phase),
        .hist_req_i  (hist_req),
        .least_req_i (least_req),
        .hist_rsp_o  (hist_rsp),
        .least_rsp_o (least_rsp),
        .axil_o      (axil_req),
        .axil_i      (axil_rsp)
    );

    huff_scratch_ram i_ram (
        .clk    (clk),
        .rst    (rst),
        .axil_i (axil_req),
        .axil_o (axil_rsp)
    );

endmodule

// File: rtl/huff_scratch_ram.sv
`timescale 1ns/1ns

module huff_scratch_ram import huff_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t axil_i,
    output axil_rsp_t axil_o
);

    word_t mem [NUM_SYMS];
    word_t rdata_q;
    logic  bvalid_q;
    logic  rvalid_q;
    logic  wr_fire;
    logic  rd_fire;
    sym_t  widx;
    sym_t  ridx;

    assign wr_fire = axil_i.awvalid && axil_i.wvalid && !bvalid_q;
    assign rd_fire = axil_i.arvalid && !rvalid_q;
    assign widx    = axil_i.awaddr[9:2];  // word index from byte address
    assign ridx    = axil_i.araddr[9:2];

    always_comb begin
        axil_o.awready = wr_fire;
        axil_o.wready  = wr_fire;
        axil_o.bvalid  = bvalid_q;
        axil_o.bresp   = AXI_OKAY;
        axil_o.arready = rd_fire;
        axil_o.rvalid  = rvalid_q;
        axil_o.rdata   = rdata_q;
        axil_o.rresp   = AXI_OKAY;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axil_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (axil_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (axil_i.wstrb[b]) mem[widx][8*b +: 8] <= axil_i.wdata[8*b +: 8];
            end
        end
        if (rd_fire) rdata_q <= mem[ridx];
    end

endmodule

// File: rtl/huff_sram_port.sv
`timescale 1ns/1ns

module huff_sram_port import huff_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  phase_t    phase_i,
    input  mem_req_t  hist_req_i,
    input  mem_req_t  least_req_i,
    output mem_rsp_t  hist_rsp_o,
    output mem_rsp_t  least_rsp_o,
    output axil_req_t axil_o,
    input  axil_rsp_t axil_i
);

    typedef enum logic [2:0] {
        P_IDLE,
        P_WADDR,
        P_BRESP,
        P_RADDR,
        P_RRESP,
        P_DONE
    } port_state_t;

    port_state_t state_q;
    axil_req_t   axil_q;
    pair_t       pair_q;
    mem_req_t    cur_req;
    byte_addr_t  base_addr;
    logic        serve_hist;
    logic        serve_least;
    logic        owner_q;  // high when least was served
    logic        word_q;   // beat within the request
    logic        two_q;
    logic        last_beat;

    assign serve_hist  = (phase_i == PH_CLEAR) || (phase_i == PH_COUNT);
    assign serve_least = (phase_i == PH_SCAN);
    assign cur_req     = serve_least ? least_req_i : hist_req_i;
    assign base_addr   = byte_addr_t'(cur_req.idx) << 2;
    assign last_beat   = (word_q == two_q);

    always_comb begin
        axil_o        = axil_q;
        axil_o.bready = (state_q == P_BRESP) && axil_i.bvalid;
        axil_o.rready = (state_q == P_RRESP) && axil_i.rvalid;
    end

    always_comb begin
        hist_rsp_o.done   = (state_q == P_DONE) && !owner_q;
        hist_rsp_o.rdata  = pair_q;
        least_rsp_o.done  = (state_q == P_DONE) && owner_q;
        least_rsp_o.rdata = pair_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= P_IDLE;
            axil_q  <= '0;
            owner_q <= 1'b0;
            word_q  <= 1'b0;
            two_q   <= 1'b0;
        end else begin
            case (state_q)
                P_IDLE: begin
                    if (cur_req.valid && (serve_hist || serve_least)) begin
                        owner_q <= serve_least;
                        two_q   <= cur_req.two_word;
                        word_q  <= 1'b0;
                        if (cur_req.write) begin
                            axil_q.awvalid <= 1'b1;
                            axil_q.awaddr  <= base_addr;
                            axil_q.wvalid  <= 1'b1;
                            axil_q.wdata   <= cur_req.wdata;  // reused for a second word
                            axil_q.wstrb   <= 4'hf;
                            state_q        <= P_WADDR;
                        end else begin
                            axil_q.arvalid <= 1'b1;
                            axil_q.araddr  <= base_addr;
                            state_q        <= P_RADDR;
                        end
                    end
                end
                P_WADDR: begin
                    if (axil_q.awvalid && axil_i.awready) axil_q.awvalid <= 1'b0;
                    if (axil_q.wvalid && axil_i.wready) axil_q.wvalid <= 1'b0;
                    if ((!axil_q.awvalid || axil_i.awready) &&
                        (!axil_q.wvalid || axil_i.wready)) begin
                        state_q <= P_BRESP;
                    end
                end
                P_BRESP: begin
                    if (axil_i.bvalid) begin
                        if (last_beat) begin
                            state_q <= P_DONE;
                        end else begin
                            word_q         <= 1'b1;
                            axil_q.awvalid <= 1'b1;
                            axil_q.wvalid  <= 1'b1;
                            axil_q.awaddr  <= axil_q.awaddr + 32'd4;
                            state_q        <= P_WADDR;
                        end
                    end
                end
                P_RADDR: begin
                    if (axil_i.arready) begin
                        axil_q.arvalid <= 1'b0;
                        state_q        <= P_RRESP;
                    end
                end
                P_RRESP: begin
                    if (axil_i.rvalid) begin
                        if (last_beat) begin
                            state_q <= P_DONE;
                        end else begin
                            word_q         <= 1'b1;
                            axil_q.arvalid <= 1'b1;
                            axil_q.araddr  <= axil_q.araddr + 32'd4;
                            state_q        <= P_RADDR;
                        end
                    end
                end
                P_DONE: state_q <= P_IDLE;
                default: state_q <= P_IDLE;
            endcase
        end
    end

    // odd entry lands in the upper word of the pair
    always_ff @(posedge clk) begin
        if (state_q == P_RRESP && axil_i.rvalid) begin
            if (word_q) begin
                pair_q[63:32] <= axil_i.rdata;
            end else begin
                pair_q[31:0] <= axil_i.rdata;
            end
        end
    end

endmodule

// File: rtl/huff_least.sv
`timescale 1ns/1ns

module huff_least import huff_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  phase_t   phase_i,
    output mem_req_t req_o,
    input  mem_rsp_t rsp_i,
    output logic     done_o,
    output least_t   result_o
);

    typedef enum logic {
        LS_IDLE,
        LS_READ
    } least_state_t;

    least_state_t state_q;
    mem_req_t     req_q;
    least_t       run_q;
    least_t       run_next;

    // ties keep the lower symbol as only a strictly smaller count replaces
    function automatic least_t take_min(least_t cur, sym_t s, cnt_t c);
        least_t r;
        r = cur;
        if (c != '0) begin
            if (cur.first_cnt == '0 || c < cur.first_cnt) begin
                r.second_sym = cur.first_sym;
                r.second_cnt = cur.first_cnt;
                r.first_sym  = s;
                r.first_cnt  = c;
            end else if (cur.second_cnt == '0 || c < cur.second_cnt) begin
                r.second_sym = s;
                r.second_cnt = c;
            end
        end
        return r;
    endfunction

    always_comb begin
        run_next = take_min(run_q, req_q.idx, rsp_i.rdata[31:0]);
        run_next = take_min(run_next, req_q.idx | 8'd1, rsp_i.rdata[63:32]);
    end

    assign req_o = req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= LS_IDLE;
            req_q    <= '0;
            run_q    <= '0;
            done_o   <= 1'b0;
            result_o <= '0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                LS_IDLE: begin
                    // phase is still scan while done is high
                    if (phase_i == PH_SCAN && !done_o) begin
                        run_q   <= '0;
                        req_q   <= '{valid: 1'b1, write: 1'b0, two_word: 1'b1,
                                     idx: '0, wdata: '0};
                        state_q <= LS_READ;
                    end
                end
                LS_READ: begin
                    if (!req_q.valid) begin
                        req_q.valid <= 1'b1;
                    end else if (rsp_i.done) begin
                        req_q.valid <= 1'b0;
                        run_q       <= run_next;
                        if (req_q.idx == sym_t'(NUM_SYMS - 2)) begin
                            result_o <= run_next;
                            done_o   <= 1'b1;
                            state_q  <= LS_IDLE;
                        end else begin
                            req_q.idx <= req_q.idx + 8'd2;  // next even entry
                        end
                    end
                end
                default: state_q <= LS_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/huff_hist.sv
`timescale 1ns/1ns

module huff_hist import huff_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  phase_t   phase_i,
    input  logic     sym_valid_i,
    input  sym_t     sym_i,
    input  logic     sym_last_i,
    output logic     sym_ready_o,
    output mem_req_t req_o,
    input  mem_rsp_t rsp_i,
    output logic     done_o
);

    typedef enum logic [2:0] {
        HS_IDLE,
        HS_CLEAR,
        HS_ACCEPT,
        HS_READ,
        HS_WRITE
    } hist_state_t;

    hist_state_t state_q;
    mem_req_t    req_q;
    logic        last_q;  // byte in flight closes the frame

    assign sym_ready_o = (state_q == HS_ACCEPT) && (phase_i == PH_COUNT);
    assign req_o = req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= HS_IDLE;
            req_q   <= '0;
            last_q  <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                HS_IDLE: begin
                    if (phase_i == PH_CLEAR) begin
                        req_q   <= '{valid: 1'b1, write: 1'b1, two_word: 1'b0,
                                     idx: '0, wdata: '0};
                        state_q <= HS_CLEAR;
                    end
                end
                HS_CLEAR: begin
                    if (!req_q.valid) begin
                        req_q.valid <= 1'b1;  // one idle cycle after each done
                    end else if (rsp_i.done) begin
                        req_q.valid <= 1'b0;
                        if (req_q.idx == sym_t'(NUM_SYMS - 1)) begin
                            done_o  <= 1'b1;
                            state_q <= HS_ACCEPT;
                        end else begin
                            req_q.idx <= req_q.idx + 1'b1;
                        end
                    end
                end
                HS_ACCEPT: begin
                    if (sym_valid_i && sym_ready_o) begin
                        req_q   <= '{valid: 1'b1, write: 1'b0, two_word: 1'b0,
                                     idx: sym_i, wdata: '0};
                        last_q  <= sym_last_i;
                        state_q <= HS_READ;
                    end
                end
                HS_READ: begin
                    if (rsp_i.done) begin
                        req_q.valid <= 1'b0;
                        req_q.write <= 1'b1;
                        req_q.wdata <= rsp_i.rdata[CNT_W-1:0] + 1'b1;
                        state_q     <= HS_WRITE;
                    end
                end
                HS_WRITE: begin
                    if (!req_q.valid) begin
                        req_q.valid <= 1'b1;
                    end else if (rsp_i.done) begin
                        req_q.valid <= 1'b0;
                        if (last_q) begin
                            done_o  <= 1'b1;
                            state_q <= HS_IDLE;
                        end else begin
                            state_q <= HS_ACCEPT;
                        end
                    end
                end
                default: state_q <= HS_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/huff_ctrl.sv
`timescale 1ns/1ns

module huff_ctrl import huff_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start_i,
    input  logic   hist_done_i,
    input  logic   least_done_i,
    output phase_t phase_o,
    output logic   done_o
);

    // frame is complete on the scan to idle step
    assign done_o = (phase_o == PH_SCAN) && least_done_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_o <= PH_IDLE;
        end else begin
            case (phase_o)
                PH_IDLE: begin
                    if (start_i) phase_o <= PH_CLEAR;
                end
                PH_CLEAR: begin
                    if (hist_done_i) phase_o <= PH_COUNT;  // table zeroed
                end
                PH_COUNT: begin
                    if (hist_done_i) phase_o <= PH_SCAN;   // last byte written back
                end
                PH_SCAN: begin
                    if (least_done_i) phase_o <= PH_IDLE;
                end
                default: phase_o <= PH_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/huff_pkg.sv
package huff_pkg;

    localparam int NUM_SYMS = 256;
    localparam int CNT_W = 32;
    localparam logic [1:0] AXI_OKAY = 2'b00;

    typedef logic [7:0]       sym_t;
    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [31:0]      word_t;
    typedef logic [63:0]      pair_t;  // even entry in the low word
    typedef logic [31:0]      byte_addr_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_CLEAR,
        PH_COUNT,
        PH_SCAN
    } phase_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        logic  two_word;
        sym_t  idx;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;
        pair_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic       awvalid;
        byte_addr_t awaddr;
        logic       wvalid;
        word_t      wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        byte_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        word_t      rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    // count of 0 marks an absent entry
    typedef struct packed {
        sym_t first_sym;
        cnt_t first_cnt;
        sym_t second_sym;
        cnt_t second_cnt;
    } least_t;

endpackage
